/* common/ex_consts.svh */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define EX_XLEN       64  // data and pc width
`define EX_ILEN       32  // instruction word
`define EX_REG_IDX_W  5   // x0..x31
`define EX_NUM_SRC    2   // rs1, rs2

// instruction field low bits, opcode sits below rd
`define EX_RD_LSB     7
`define EX_RS1_LSB    15
`define EX_RS2_LSB    20

// rv64i major opcodes, inst[6:0]
`define EX_OPC_OP      7'b0110011
`define EX_OPC_OP_IMM  7'b0010011
`define EX_OPC_LUI     7'b0110111
`define EX_OPC_AUIPC   7'b0010111
`define EX_OPC_LOAD    7'b0000011
`define EX_OPC_JAL     7'b1101111

`define EX_PC_STEP    4   // sequential fetch step, no compressed

`endif

/* common/ex_pkg.sv */
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

    // basic data words
    typedef logic [`EX_XLEN-1:0]      xlen_t;
    typedef logic [`EX_ILEN-1:0]      inst_t;
    typedef logic [`EX_REG_IDX_W-1:0] reg_idx_t;

    // integer alu operations, register and immediate forms share these
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // operand a source
    typedef enum logic [1:0] {
        src_a_rs1  = 2'd0,  // normal reg ops, jalr, stores
        src_a_pc   = 2'd1,  // auipc, jal
        src_a_zero = 2'd2   // lui
    } src_a_sel_t;

    // what the stage does with the alu result
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_jump   = 2'd1,  // jal / jalr, link + redirect
        kind_branch = 2'd2,
        kind_store  = 2'd3   // result is the store address
    } ex_kind_t;

    // branch conditions, encoded as funct3
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } br_cond_t;

    // decoded control from ID, 12 bits
    typedef struct packed {
        alu_op_t    alu_op;
        src_a_sel_t src_a_sel;
        logic       use_imm;   // operand b = imm instead of rs2
        ex_kind_t   kind;
        br_cond_t   br_cond;   // only looked at for branches
    } ex_ctrl_t;

endpackage

`default_nettype wire

/* common/bypass_if.sv */
`default_nettype none
`timescale 1ns/100ps

// classified MEM/WB producers, one source, many readers
interface bypass_if import ex_pkg::*; ();

    logic     mem_hit;   // mem producer valid, writes rd, rd != 0
    reg_idx_t mem_rd;
    xlen_t    mem_data;  // alu result in mem

    logic     wb_hit;
    reg_idx_t wb_rd;
    xlen_t    wb_data;   // final write data incl. loads

    modport src (
        output mem_hit, mem_rd, mem_data,
        output wb_hit, wb_rd, wb_data
    );

    modport fwd (
        input mem_hit, mem_rd, mem_data,
        input wb_hit, wb_rd, wb_data
    );

endinterface

`default_nettype wire

/* hdl/ex_stage_reg.sv */
`default_nettype none
`timescale 1ns/100ps

module ex_stage_reg import ex_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,      // level, kills the held instruction
    input  logic     valid_in,
    input  logic     ready_out,  // memory side ready, also our load enable
    input  xlen_t    pc_in,
    input  inst_t    inst_in,
    input  ex_ctrl_t ctrl_in,
    input  xlen_t    src_a_in,
    input  xlen_t    src_b_in,
    input  xlen_t    imm_in,
    output logic     valid,
    output xlen_t    pc,
    output inst_t    inst,
    output ex_ctrl_t ctrl,
    output xlen_t    src_a,
    output xlen_t    src_b,
    output xlen_t    imm
);

    // valid bit, only control state here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;  // flush beats stall
        end else if (ready_out) begin
            valid <= valid_in;
        end
    end

    // payload, loaded on the same enable, held under back-pressure
    always_ff @(posedge clk) begin
        if (ready_out) begin
            pc    <= pc_in;
            inst  <= inst_in;
            ctrl  <= ctrl_in;
            src_a <= src_a_in;
            src_b <= src_b_in;
            imm   <= imm_in;
        end
    end

    // memory stage relies on a stalled instruction not changing under it
    held_inst_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid && !ready_out |=> $stable(pc) && $stable(inst)
    ) else $error("ex_stage_reg: held pc/inst changed while stalled");

endmodule

`default_nettype wire

/* forwarding/bypass_source.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ex_consts.svh"

module bypass_source import ex_pkg::*; (
    input  logic   mem_valid,
    input  inst_t  mem_inst,
    input  xlen_t  mem_result,  // alu output latched into mem
    input  logic   wb_valid,
    input  inst_t  wb_inst,
    input  xlen_t  wb_wdata,    // value going into the regfile
    bypass_if.src  byp
);

    // does this opcode write rd, with data usable at this stage
    function automatic logic writes_rd(input inst_t word, input logic wb_stage);
        logic [`EX_RD_LSB-1:0] opc;
        logic                  wr;
        opc = word[`EX_RD_LSB-1:0];
        case (opc)
            `EX_OPC_OP,
            `EX_OPC_OP_IMM,
            `EX_OPC_LUI,
            `EX_OPC_AUIPC: wr = 1'b1;
            // load data and jal link only exist once in wb
            `EX_OPC_LOAD,
            `EX_OPC_JAL:   wr = wb_stage;
            default:       wr = 1'b0;  // stores, branches, system
        endcase
        return wr;
    endfunction

    reg_idx_t mem_rd_field;
    reg_idx_t wb_rd_field;
    logic     mem_wr;
    logic     wb_wr;

    assign mem_rd_field = mem_inst[`EX_RD_LSB +: `EX_REG_IDX_W];
    assign wb_rd_field  = wb_inst[`EX_RD_LSB +: `EX_REG_IDX_W];

    assign mem_wr = writes_rd(mem_inst, 1'b0);
    assign wb_wr  = writes_rd(wb_inst, 1'b1);

    // x0 never forwards
    assign byp.mem_hit  = mem_valid && mem_wr && (mem_rd_field != '0);
    assign byp.mem_rd   = mem_rd_field;
    assign byp.mem_data = mem_result;

    assign byp.wb_hit  = wb_valid && wb_wr && (wb_rd_field != '0);
    assign byp.wb_rd   = wb_rd_field;
    assign byp.wb_data = wb_wdata;

endmodule

`default_nettype wire

/* forwarding/operand_fwd.sv */
`default_nettype none
`timescale 1ns/100ps

module operand_fwd import ex_pkg::*; (
    input  reg_idx_t rs_idx,   // source field of the ex instruction
    input  xlen_t    reg_val,  // value read in decode
    bypass_if.fwd    byp,
    output xlen_t    operand
);

    logic mem_match;
    logic wb_match;

    assign mem_match = byp.mem_hit && (byp.mem_rd == rs_idx);
    assign wb_match  = byp.wb_hit && (byp.wb_rd == rs_idx);

    // youngest producer wins, mem before wb
    always_comb begin
        if (mem_match) begin
            operand = byp.mem_data;
        end else if (wb_match) begin
            operand = byp.wb_data;
        end else begin
            operand = reg_val;  // no hazard
        end
    end

    // a zero-index hit would hijack every x0 read
    mem_hit_rd_nonzero: assert final (!byp.mem_hit || byp.mem_rd != '0)
        else $error("operand_fwd: mem_hit with mem_rd == 0");

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ex_consts.svh"

module exec_unit import ex_pkg::*; (
    input  logic     valid,
    input  logic     ready_out,
    input  xlen_t    pc,
    input  ex_ctrl_t ctrl,
    input  xlen_t    rs1_val,     // already forwarded
    input  xlen_t    rs2_val,     // already forwarded
    input  xlen_t    imm,
    output xlen_t    result,      // alu value, link addr or store addr
    output xlen_t    store_data,
    output xlen_t    dnpc,
    output logic     pc_update    // one-cycle redirect to fetch
);

    xlen_t                       op_a;
    xlen_t                       op_b;
    xlen_t                       alu_sum;
    xlen_t                       alu_out;
    xlen_t                       snpc;
    xlen_t                       br_target;
    logic [$clog2(`EX_XLEN)-1:0] shamt;
    logic                        br_taken;

    // operand a
    always_comb begin
        case (ctrl.src_a_sel)
            src_a_rs1: op_a = rs1_val;
            src_a_pc:  op_a = pc;      // auipc, jal
            default:   op_a = '0;      // lui
        endcase
    end

    assign op_b    = ctrl.use_imm ? imm : rs2_val;
    assign shamt   = op_b[$clog2(`EX_XLEN)-1:0];  // rv64 shifts use 6 bits
    assign alu_sum = op_a + op_b;  // also jump target and store address

    // alu
    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_out = alu_sum;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_slt:  alu_out = xlen_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_out = xlen_t'(op_a < op_b);
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = xlen_t'($signed(op_a) >>> shamt);
            alu_or:   alu_out = op_a | op_b;
            alu_and:  alu_out = op_a & op_b;
            default:  alu_out = alu_sum;
        endcase
    end

    // branch compare, always on the register operands
    always_comb begin
        case (ctrl.br_cond)
            br_eq:   br_taken = (rs1_val == rs2_val);
            br_ne:   br_taken = (rs1_val != rs2_val);
            br_lt:   br_taken = ($signed(rs1_val) < $signed(rs2_val));
            br_ge:   br_taken = ($signed(rs1_val) >= $signed(rs2_val));
            br_ltu:  br_taken = (rs1_val < rs2_val);
            br_geu:  br_taken = (rs1_val >= rs2_val);
            default: br_taken = 1'b0;
        endcase
    end

    assign snpc      = pc + xlen_t'(`EX_PC_STEP);
    assign br_target = pc + imm;  // own adder, alu busy with nothing else though

    // result, next pc and redirect
    always_comb begin
        result    = alu_out;
        dnpc      = snpc;
        pc_update = 1'b0;
        case (ctrl.kind)
            kind_jump: begin
                result    = snpc;     // link address
                dnpc      = alu_sum;  // jal pc+imm, jalr rs1+imm
                pc_update = valid && ready_out;
            end
            kind_branch: begin
                if (br_taken) begin
                    dnpc = br_target;
                end
                pc_update = valid && ready_out && br_taken;
            end
            default: begin
                // alu and store keep alu_out, fall through to snpc
            end
        endcase
    end

    assign store_data = rs2_val;  // sd/sw/sh/sb data, mem does the lane select

    // bubbles must never steer fetch
    pc_update_needs_valid: assert final (!pc_update || valid)
        else $error("exec_unit: pc_update without a valid instruction");

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ex_consts.svh"

module ex_stage import ex_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    // from decode
    input  logic     valid_in,
    output logic     ready_in,
    input  xlen_t    pc_in,
    input  inst_t    inst_in,
    input  ex_ctrl_t ctrl_in,
    input  xlen_t    src_a_in,
    input  xlen_t    src_b_in,
    input  xlen_t    imm_in,
    // producers further down the pipe
    input  logic     mem_valid,
    input  inst_t    mem_inst,
    input  xlen_t    mem_result,
    input  logic     wb_valid,
    input  inst_t    wb_inst,
    input  xlen_t    wb_wdata,
    // to memory
    output logic     valid_out,
    input  logic     ready_out,
    output xlen_t    pc_out,
    output inst_t    inst_out,
    output xlen_t    result_out,
    output xlen_t    store_data_out,
    // redirect to fetch
    output xlen_t    dnpc,
    output logic     pc_update
);

    logic     ex_valid;
    xlen_t    ex_pc;
    inst_t    ex_inst;
    ex_ctrl_t ex_ctrl;
    xlen_t    ex_src_a;
    xlen_t    ex_src_b;
    xlen_t    ex_imm;

    reg_idx_t rs_idx  [`EX_NUM_SRC];
    xlen_t    reg_val [`EX_NUM_SRC];
    xlen_t    fwd_val [`EX_NUM_SRC];

    assign ready_in = ready_out;  // no multicycle ops, stall only from memory

    ex_stage_reg u_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .valid_in  (valid_in),
        .ready_out (ready_out),
        .pc_in     (pc_in),
        .inst_in   (inst_in),
        .ctrl_in   (ctrl_in),
        .src_a_in  (src_a_in),
        .src_b_in  (src_b_in),
        .imm_in    (imm_in),
        .valid     (ex_valid),
        .pc        (ex_pc),
        .inst      (ex_inst),
        .ctrl      (ex_ctrl),
        .src_a     (ex_src_a),
        .src_b     (ex_src_b),
        .imm       (ex_imm)
    );

    bypass_if byp ();

    bypass_source u_bypass_src (
        .mem_valid  (mem_valid),
        .mem_inst   (mem_inst),
        .mem_result (mem_result),
        .wb_valid   (wb_valid),
        .wb_inst    (wb_inst),
        .wb_wdata   (wb_wdata),
        .byp        (byp.src)
    );

    // slot 0 = rs1 / src_a, slot 1 = rs2 / src_b
    assign rs_idx[0]  = ex_inst[`EX_RS1_LSB +: `EX_REG_IDX_W];
    assign rs_idx[1]  = ex_inst[`EX_RS2_LSB +: `EX_REG_IDX_W];
    assign reg_val[0] = ex_src_a;
    assign reg_val[1] = ex_src_b;

    for (genvar i = 0; i < `EX_NUM_SRC; i++) begin : g_fwd
        operand_fwd u_fwd (
            .rs_idx  (rs_idx[i]),
            .reg_val (reg_val[i]),
            .byp     (byp.fwd),
            .operand (fwd_val[i])
        );
    end

    exec_unit u_exec (
        .valid      (ex_valid),
        .ready_out  (ready_out),
        .pc         (ex_pc),
        .ctrl       (ex_ctrl),
        .rs1_val    (fwd_val[0]),
        .rs2_val    (fwd_val[1]),
        .imm        (ex_imm),
        .result     (result_out),
        .store_data (store_data_out),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    assign valid_out = ex_valid;
    assign pc_out    = ex_pc;
    assign inst_out  = ex_inst;

endmodule

`default_nettype wire

/* verification/tb_ex_stage.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ex_consts.svh"

module tb_ex_stage import ex_pkg::*; ();

    // per-test lengths in cycles whose doubled sum bounds the run
    localparam int reset_cycles = 10;
    localparam int alu_len      = 45;
    localparam int fwd_len      = 9;
    localparam int x0_len       = 5;
    localparam int br_len       = 65;
    localparam int stall_len    = 9;
    localparam int flush_len    = 12;
    localparam int max_cycles   = 2 * (reset_cycles + alu_len + fwd_len + x0_len + br_len
                                       + stall_len + flush_len + 2);
    localparam int msb          = `EX_XLEN - 1;

    logic     clk;
    logic     arst_n;
    logic     flush;
    logic     valid_in;
    logic     ready_in;
    xlen_t    pc_in;
    inst_t    inst_in;
    ex_ctrl_t ctrl_in;
    xlen_t    src_a_in;
    xlen_t    src_b_in;
    xlen_t    imm_in;
    logic     mem_valid;
    inst_t    mem_inst;
    xlen_t    mem_result;
    logic     wb_valid;
    inst_t    wb_inst;
    xlen_t    wb_wdata;
    logic     valid_out;
    logic     ready_out;
    xlen_t    pc_out;
    inst_t    inst_out;
    xlen_t    result_out;
    xlen_t    store_data_out;
    xlen_t    dnpc;
    logic     pc_update;

    int seed            = 7;
    int errors          = 0;
    int tests_run       = 0;
    int test_start_errs = 0;
    int cycles          = 0;

    ex_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reference copy of the bundle accepted on the last edge
    logic     m_valid;
    xlen_t    m_pc;
    inst_t    m_inst;
    ex_ctrl_t m_ctrl;
    xlen_t    m_a;
    xlen_t    m_b;
    xlen_t    m_imm;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else begin
            if (flush) m_valid <= 1'b0;
            else if (ready_out) m_valid <= valid_in;
            if (ready_out) begin  // payload follows the accept edge only
                m_pc   <= pc_in;
                m_inst <= inst_in;
                m_ctrl <= ctrl_in;
                m_a    <= src_a_in;
                m_b    <= src_b_in;
                m_imm  <= imm_in;
            end
        end
    end

    // producer writes rd with usable data (wb also has loads and jal)
    function automatic logic producer_hit(input logic v, input inst_t w, input logic late);
        logic [6:0] opc;
        logic       wr;
        opc = w[6:0];
        wr  = (opc inside {`EX_OPC_OP, `EX_OPC_OP_IMM, `EX_OPC_LUI, `EX_OPC_AUIPC})
              || (late && (opc inside {`EX_OPC_LOAD, `EX_OPC_JAL}));
        return v && wr && (w[`EX_RD_LSB +: `EX_REG_IDX_W] != 0);
    endfunction

    function automatic xlen_t alu_ref(input alu_op_t op, input xlen_t a, input xlen_t b);
        int unsigned sh;
        xlen_t       fill;
        logic        lt_s;
        sh   = b[5:0];
        fill = a[msb] ? ~({`EX_XLEN{1'b1}} >> sh) : '0;  // sign bits shifted in
        lt_s = (a[msb] != b[msb]) ? a[msb] : (a < b);
        case (op)
            alu_sub:  return a + ~b + 1;
            alu_sll:  return a << sh;
            alu_slt:  return xlen_t'(lt_s);
            alu_sltu: return xlen_t'(a < b);
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | fill;
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic branch_ref(input br_cond_t c, input xlen_t a, input xlen_t b);
        xlen_t flip;
        logic  lt_s;
        flip = xlen_t'(1) << msb;
        lt_s = (a ^ flip) < (b ^ flip);  // signed compare by msb flip
        case (c)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_lt:   return lt_s;
            br_ge:   return !lt_s;
            br_ltu:  return a < b;
            br_geu:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     mem_hit_m;
    logic     wb_hit_m;
    xlen_t    exp_rs1;
    xlen_t    exp_rs2;
    xlen_t    exp_a;
    xlen_t    exp_b;
    logic     exp_taken;
    xlen_t    exp_result;
    xlen_t    exp_dnpc;
    logic     exp_pc_update;

    assign rs1_idx   = m_inst[`EX_RS1_LSB +: `EX_REG_IDX_W];
    assign rs2_idx   = m_inst[`EX_RS2_LSB +: `EX_REG_IDX_W];
    assign mem_hit_m = producer_hit(mem_valid, mem_inst, 1'b0);
    assign wb_hit_m  = producer_hit(wb_valid, wb_inst, 1'b1);
    // mem first, then wb, then decode value
    assign exp_rs1 = (mem_hit_m && mem_inst[`EX_RD_LSB +: `EX_REG_IDX_W] == rs1_idx) ? mem_result
                   : (wb_hit_m && wb_inst[`EX_RD_LSB +: `EX_REG_IDX_W] == rs1_idx) ? wb_wdata
                   : m_a;
    assign exp_rs2 = (mem_hit_m && mem_inst[`EX_RD_LSB +: `EX_REG_IDX_W] == rs2_idx) ? mem_result
                   : (wb_hit_m && wb_inst[`EX_RD_LSB +: `EX_REG_IDX_W] == rs2_idx) ? wb_wdata
                   : m_b;

    always_comb begin
        case (m_ctrl.src_a_sel)
            src_a_rs1: exp_a = exp_rs1;
            src_a_pc:  exp_a = m_pc;
            default:   exp_a = '0;
        endcase
        exp_b      = m_ctrl.use_imm ? m_imm : exp_rs2;
        exp_taken  = (m_ctrl.kind == kind_branch) && branch_ref(m_ctrl.br_cond, exp_rs1, exp_rs2);
        exp_result = (m_ctrl.kind == kind_jump) ? m_pc + `EX_PC_STEP
                                                : alu_ref(m_ctrl.alu_op, exp_a, exp_b);
        if (m_ctrl.kind == kind_jump) exp_dnpc = exp_a + exp_b;
        else if (exp_taken) exp_dnpc = m_pc + m_imm;
        else exp_dnpc = m_pc + `EX_PC_STEP;
        exp_pc_update = m_valid && ready_out && (m_ctrl.kind == kind_jump || exp_taken);
    end

    chk_valid: assert property (@(posedge clk) disable iff (!arst_n) valid_out == m_valid)
        else begin
            errors++;
            $display("Error: %0t ns, valid_out %b, expected %b", $time,
                     $sampled(valid_out), $sampled(m_valid));
        end
    chk_pc_inst: assert property (@(posedge clk) disable iff (!arst_n)
        m_valid |-> pc_out == m_pc && inst_out == m_inst)
        else begin
            errors++;
            $display("Error: %0t ns, pc_out %h inst_out %h, expected %h %h", $time,
                     $sampled(pc_out), $sampled(inst_out), $sampled(m_pc), $sampled(m_inst));
        end
    chk_result: assert property (@(posedge clk) disable iff (!arst_n)
        m_valid |-> result_out == exp_result)
        else begin
            errors++;
            $display("Error: %0t ns, result_out %h, expected %h", $time,
                     $sampled(result_out), $sampled(exp_result));
        end
    chk_store: assert property (@(posedge clk) disable iff (!arst_n)
        m_valid |-> store_data_out == exp_rs2)
        else begin
            errors++;
            $display("Error: %0t ns, store_data_out %h, expected %h", $time,
                     $sampled(store_data_out), $sampled(exp_rs2));
        end
    chk_dnpc: assert property (@(posedge clk) disable iff (!arst_n) m_valid |-> dnpc == exp_dnpc)
        else begin
            errors++;
            $display("Error: %0t ns, dnpc %h, expected %h", $time,
                     $sampled(dnpc), $sampled(exp_dnpc));
        end
    chk_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        pc_update == exp_pc_update)
        else begin
            errors++;
            $display("Error: %0t ns, pc_update %b, expected %b", $time,
                     $sampled(pc_update), $sampled(exp_pc_update));
        end
    chk_ready: assert property (@(posedge clk) ready_in == ready_out)
        else begin
            errors++;
            $display("Error: %0t ns, ready_in does not follow ready_out", $time);
        end
    chk_hold: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> $stable(result_out) && $stable(dnpc) && $stable(pc_out))
        else begin
            errors++;
            $display("Error: %0t ns, outputs changed under back-pressure", $time);
        end
    chk_stall_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !ready_out |-> !pc_update)
        else begin
            errors++;
            $display("Error: %0t ns, pc_update high while ready_out low", $time);
        end
    chk_flush: assert property (@(posedge clk) disable iff (!arst_n) flush |=> !valid_out)
        else begin
            errors++;
            $display("Error: %0t ns, valid_out still high after flush", $time);
        end
    chk_reset: assert property (@(posedge clk) !arst_n |=> !valid_out)
        else begin
            errors++;
            $display("Error: %0t ns, valid_out still high after reset", $time);
        end

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic ex_ctrl_t make_ctrl(input alu_op_t op, input src_a_sel_t sa,
                                           input logic ui, input ex_kind_t k,
                                           input br_cond_t bc);
        ex_ctrl_t c;
        c.alu_op    = op;
        c.src_a_sel = sa;
        c.use_imm   = ui;
        c.kind      = k;
        c.br_cond   = bc;
        return c;
    endfunction

    function automatic inst_t make_inst(input logic [6:0] opc, input reg_idx_t rd,
                                        input reg_idx_t rs1, input reg_idx_t rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, opc};
    endfunction

    // decode bundle only with no waiting
    task automatic drive_bundle(input ex_ctrl_t c, input inst_t i, input xlen_t a,
                                input xlen_t b, input xlen_t im);
        valid_in <= 1'b1;
        pc_in    <= rand64() & ~xlen_t'(3);  // word aligned
        ctrl_in  <= c;
        inst_in  <= i;
        src_a_in <= a;
        src_b_in <= b;
        imm_in   <= im;
    endtask

    // returns on the accept edge so the op sits in ex for the next cycle
    task automatic run_op(input ex_ctrl_t c, input inst_t i, input xlen_t a, input xlen_t b,
                          input xlen_t im);
        @(posedge clk);
        drive_bundle(c, i, a, b, im);
        @(posedge clk);
        valid_in  <= 1'b0;
        mem_valid <= 1'b0;  // no producers unless the caller sets them
        wb_valid  <= 1'b0;
    endtask

    task automatic set_producers(input logic mv, input inst_t mi, input xlen_t mr,
                                 input logic wv, input inst_t wi, input xlen_t wd);
        mem_valid  <= mv;
        mem_inst   <= mi;
        mem_result <= mr;
        wb_valid   <= wv;
        wb_inst    <= wi;
        wb_wdata   <= wd;
    endtask

    task automatic report_test(input string name);
        @(posedge clk);  // last op checked on this edge
        #1;
        $display("%s: %0d failed checks", name, errors - test_start_errs);
        tests_run++;
        test_start_errs = errors;
    endtask

    task automatic alu_sweep();
        for (int i = 0; i < 10; i++) begin
            for (int u = 0; u < 2; u++) begin
                run_op(make_ctrl(alu_op_t'(i), src_a_rs1, u[0], kind_alu, br_eq),
                       make_inst(u[0] ? `EX_OPC_OP_IMM : `EX_OPC_OP, 3, 4, 5),
                       rand64(), rand64(), rand64());
            end
        end
        run_op(make_ctrl(alu_add, src_a_zero, 1'b1, kind_alu, br_eq),
               make_inst(`EX_OPC_LUI, 3, 0, 0), rand64(), rand64(), rand64());  // lui
        run_op(make_ctrl(alu_add, src_a_pc, 1'b1, kind_alu, br_eq),
               make_inst(`EX_OPC_AUIPC, 3, 0, 0), rand64(), rand64(), rand64());  // auipc
    endtask

    task automatic forward_paths();
        ex_ctrl_t add_rr;
        add_rr = make_ctrl(alu_add, src_a_rs1, 1'b0, kind_alu, br_eq);
        // mem and wb both write x5 and mem is younger
        run_op(add_rr, make_inst(`EX_OPC_OP, 3, 5, 6), rand64(), rand64(), '0);
        set_producers(1'b1, make_inst(`EX_OPC_OP, 5, 1, 2), rand64(),
                      1'b1, make_inst(`EX_OPC_OP, 5, 1, 2), rand64());
        // load in mem has no data yet
        run_op(add_rr, make_inst(`EX_OPC_OP, 3, 6, 7), rand64(), rand64(), '0);
        set_producers(1'b1, make_inst(`EX_OPC_LOAD, 6, 1, 0), rand64(), 1'b0, '0, '0);
        // same load one stage later
        run_op(add_rr, make_inst(`EX_OPC_OP, 3, 6, 7), rand64(), rand64(), '0);
        set_producers(1'b0, '0, '0, 1'b1, make_inst(`EX_OPC_LOAD, 6, 1, 0), rand64());
        // store base from auipc in mem and store data from jal link in wb
        run_op(make_ctrl(alu_add, src_a_rs1, 1'b1, kind_store, br_eq),
               make_inst(7'b0100011, 0, 8, 7), rand64(), rand64(), rand64());
        set_producers(1'b1, make_inst(`EX_OPC_AUIPC, 8, 0, 0), rand64(),
                      1'b1, make_inst(`EX_OPC_JAL, 7, 0, 0), rand64());
    endtask

    task automatic zero_rd_producers();
        run_op(make_ctrl(alu_or, src_a_rs1, 1'b0, kind_alu, br_eq),
               make_inst(`EX_OPC_OP, 0, 0, 0), rand64(), rand64(), '0);
        set_producers(1'b1, make_inst(`EX_OPC_OP, 0, 0, 0), rand64(),
                      1'b1, make_inst(`EX_OPC_LOAD, 0, 0, 0), rand64());
        run_op(make_ctrl(alu_add, src_a_rs1, 1'b1, kind_store, br_eq),
               make_inst(7'b0100011, 0, 0, 0), rand64(), rand64(), rand64());
        set_producers(1'b1, make_inst(`EX_OPC_LUI, 0, 0, 0), rand64(),
                      1'b1, make_inst(`EX_OPC_JAL, 0, 0, 0), rand64());
    endtask

    task automatic branch_jump_sweep();
        xlen_t    lhs   [5];
        xlen_t    rhs   [5];
        br_cond_t conds [6];
        // equal, less, greater, then sign-split pairs
        lhs   = '{64'd5, 64'd3, 64'd9, 64'hffff_ffff_ffff_fffe, 64'd4};
        rhs   = '{64'd5, 64'd9, 64'd3, 64'd4, 64'hffff_ffff_ffff_fffe};
        conds = '{br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu};
        foreach (conds[c]) begin
            foreach (lhs[p]) begin
                run_op(make_ctrl(alu_add, src_a_rs1, 1'b0, kind_branch, conds[c]),
                       make_inst(7'b1100011, 0, 1, 2), lhs[p], rhs[p], rand64() & ~xlen_t'(1));
            end
        end
        run_op(make_ctrl(alu_add, src_a_pc, 1'b1, kind_jump, br_eq),
               make_inst(`EX_OPC_JAL, 1, 0, 0), rand64(), rand64(), rand64());  // jal
        run_op(make_ctrl(alu_add, src_a_rs1, 1'b1, kind_jump, br_eq),
               make_inst(7'b1100111, 1, 9, 0), rand64(), rand64(), rand64());  // jalr
    endtask

    task automatic stall_release();
        run_op(make_ctrl(alu_add, src_a_pc, 1'b1, kind_jump, br_eq),
               make_inst(`EX_OPC_JAL, 1, 0, 0), rand64(), rand64(), rand64());
        ready_out <= 1'b0;  // jump held in ex
        drive_bundle(make_ctrl(alu_xor, src_a_rs1, 1'b0, kind_alu, br_eq),
                     make_inst(`EX_OPC_OP, 3, 4, 5), rand64(), rand64(), '0);
        repeat (4) @(posedge clk);
        ready_out <= 1'b1;  // redirect goes out in this cycle
        @(posedge clk);
        valid_in <= 1'b0;
    endtask

    task automatic flush_then_reset();
        run_op(make_ctrl(alu_add, src_a_rs1, 1'b0, kind_alu, br_eq),
               make_inst(`EX_OPC_OP, 3, 4, 5), rand64(), rand64(), '0);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);
        run_op(make_ctrl(alu_add, src_a_pc, 1'b1, kind_jump, br_eq),
               make_inst(`EX_OPC_JAL, 1, 0, 0), rand64(), rand64(), rand64());
        arst_n <= 1'b0;  // mid-run reset
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: run did not end within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        arst_n     = 1'b0;
        flush      = 1'b0;
        valid_in   = 1'b0;
        ready_out  = 1'b1;
        pc_in      = '0;
        inst_in    = '0;
        ctrl_in    = '0;
        src_a_in   = '0;
        src_b_in   = '0;
        imm_in     = '0;
        mem_valid  = 1'b0;
        mem_inst   = '0;
        mem_result = '0;
        wb_valid   = 1'b0;
        wb_inst    = '0;
        wb_wdata   = '0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        alu_sweep();
        report_test("alu ops");
        forward_paths();
        report_test("forwarding");
        zero_rd_producers();
        report_test("x0 producers");
        branch_jump_sweep();
        report_test("branches and jumps");
        stall_release();
        report_test("back-pressure");
        flush_then_reset();
        report_test("flush and reset");
        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed checks", tests_run, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/ex_pkg.sv
common/bypass_if.sv
hdl/ex_stage_reg.sv
forwarding/bypass_source.sv
forwarding/operand_fwd.sv
hdl/exec_unit.sv
hdl/ex_stage.sv
verification/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ex_pkg.sv
      - common/bypass_if.sv
      - hdl/ex_stage_reg.sv
      - forwarding/bypass_source.sv
      - forwarding/operand_fwd.sv
      - hdl/exec_unit.sv
      - hdl/ex_stage.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/tb_ex_stage.sv
